// ==== dv/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb import exec_pkg::*; ();

  localparam int num_entries     = 24;
  localparam int watchdog_cycles = num_entries + 3 + 20;  // Table, reset and margin

  typedef struct packed {
    logic                      issue;
    logic                      is_branch;
    alu_fn_t                   alu_fn;
    br_fn_t                    br_fn;
    op1_sel_t                  op1_sel;
    op2_sel_t                  op2_sel;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           rs1;
    logic [xlen-1:0]           rs2;
    logic [xlen-1:0]           imm;
    logic [xlen-1:0]           pc;
    logic [1:0]                rnd;  // Bit 1 draws rs1, bit 0 draws rs2
  } op_entry_t;

  typedef struct packed {
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0]           wb_data;
    logic                      br_valid;
    logic                      br_taken;
    logic [xlen-1:0]           br_target;
  } result_t;

  logic                      clock;
  logic                      reset;
  logic                      issue;
  logic                      is_branch;
  alu_fn_t                   alu_fn;
  br_fn_t                    br_fn;
  op1_sel_t                  op1_sel;
  op2_sel_t                  op2_sel;
  logic [xlen-1:0]           pc;
  logic [xlen-1:0]           rs1_data;
  logic [xlen-1:0]           rs2_data;
  logic [xlen-1:0]           imm;
  logic [reg_addr_width-1:0] rd;
  logic                      wb_valid;
  logic [reg_addr_width-1:0] wb_rd;
  logic [xlen-1:0]           wb_data;
  logic                      br_valid;
  logic                      br_taken;
  logic [xlen-1:0]           br_target;

  op_entry_t stim [num_entries];
  int        errors;
  int        checks;

  exec_unit dut (.*);

  always #5 clock = ~clock;

  // ==========================================================================
  // Table entries and reference model
  // ==========================================================================

  function automatic op_entry_t alu_op(alu_fn_t fn, op1_sel_t s1, op2_sel_t s2,
      logic [reg_addr_width-1:0] r, logic [xlen-1:0] a, logic [xlen-1:0] b,
      logic [xlen-1:0] i, logic [xlen-1:0] p, logic [1:0] rnd);
    return '{1'b1, 1'b0, fn, BR_EQ, s1, s2, r, a, b, i, p, rnd};
  endfunction

  // Branches carry a nonzero rd so a stray write would show up
  // PC and immediate on the ALU side keep the muxed operands apart from the registers
  function automatic op_entry_t br_op(br_fn_t fn, logic [xlen-1:0] a, logic [xlen-1:0] b,
      logic [xlen-1:0] i, logic [xlen-1:0] p, logic [1:0] rnd);
    return '{1'b1, 1'b1, FN_ADD, fn, OP1_PC, OP2_IMM, 5'd17, a, b, i, p, rnd};
  endfunction

  // A negative operand is the smaller one when the signs differ
  function automatic logic signed_less(logic [xlen-1:0] a, logic [xlen-1:0] b);
    if (a[xlen-1] != b[xlen-1]) begin
      return a[xlen-1];
    end
    return a < b;
  endfunction

  function automatic result_t model_result(op_entry_t e, logic [xlen-1:0] a,
                                           logic [xlen-1:0] b);
    logic [xlen-1:0]        x;
    logic [xlen-1:0]        y;
    logic [shamt_width-1:0] sh;
    logic [2*xlen-1:0]      fill;
    result_t                r;
    x    = (e.op1_sel == OP1_PC) ? e.pc : a;
    y    = (e.op2_sel == OP2_IMM) ? e.imm : b;
    sh   = y[shamt_width-1:0];
    fill = {{xlen{x[xlen-1]}}, x} >> sh;  // Sign copies move down into the low word
    r    = '0;
    case (e.alu_fn)
      FN_ADD:  r.wb_data = x + y;
      FN_SUB:  r.wb_data = x + ~y + xlen'(1);
      FN_SLT:  r.wb_data = xlen'(signed_less(x, y));
      FN_SLTU: r.wb_data = xlen'(x < y);
      FN_XOR:  r.wb_data = x ^ y;
      FN_OR:   r.wb_data = x | y;
      FN_AND:  r.wb_data = x & y;
      FN_SLL:  r.wb_data = x << sh;
      FN_SRL:  r.wb_data = x >> sh;
      FN_SRA:  r.wb_data = fill[xlen-1:0];
      default: r.wb_data = '0;
    endcase
    // Branch conditions always look at the raw register values
    case (e.br_fn)
      BR_EQ:   r.br_taken = (a == b);
      BR_NE:   r.br_taken = (a != b);
      BR_LT:   r.br_taken = signed_less(a, b);
      BR_GE:   r.br_taken = !signed_less(a, b);  // Equal is taken
      BR_LTU:  r.br_taken = (a < b);
      BR_GEU:  r.br_taken = (a >= b);
      default: r.br_taken = 1'b0;
    endcase
    r.wb_valid  = e.issue && !e.is_branch && (e.rd != '0);
    r.wb_rd     = e.rd;
    r.br_valid  = e.issue && e.is_branch;
    r.br_target = e.pc + e.imm;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("MISMATCH at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin
    result_t         pending;
    result_t         predicted;
    op_entry_t       e;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;

    void'($urandom(32'h3ea4_d101));
    clock     = 1'b0;
    reset     = 1'b1;
    issue     = 1'b0;
    is_branch = 1'b0;
    alu_fn    = FN_ADD;
    br_fn     = BR_EQ;
    op1_sel   = OP1_RS1;
    op2_sel   = OP2_RS2;
    pc        = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    imm       = '0;
    rd        = '0;
    errors    = 0;
    checks    = 0;

    stim[0]  = alu_op(FN_ADD, OP1_RS1, OP2_RS2, 5'd1, 32'd5, 32'd7, 32'd0, 32'd0, 2'b00);
    stim[1]  = alu_op(FN_SUB, OP1_RS1, OP2_RS2, 5'd2, 32'd0, 32'd1, 32'd0, 32'd0, 2'b00);
    stim[2]  = alu_op(FN_SLT, OP1_RS1, OP2_RS2, 5'd3, 32'hffff_fff0, 32'd16, 32'd0, 32'd0, 2'b00);
    stim[3]  = alu_op(FN_SLTU, OP1_RS1, OP2_RS2, 5'd4, 32'hffff_fff0, 32'd16, 32'd0, 32'd0, 2'b00);
    stim[4]  = alu_op(FN_XOR, OP1_RS1, OP2_RS2, 5'd5, 32'd0, 32'd0, 32'd0, 32'd0, 2'b11);
    stim[5]  = alu_op(FN_OR, OP1_RS1, OP2_RS2, 5'd6, 32'd0, 32'd0, 32'd0, 32'd0, 2'b11);
    stim[6]  = alu_op(FN_AND, OP1_RS1, OP2_RS2, 5'd7, 32'd0, 32'd0, 32'd0, 32'd0, 2'b11);
    stim[7]  = alu_op(FN_SLL, OP1_RS1, OP2_RS2, 5'd8, 32'd1, 32'd31, 32'd0, 32'd0, 2'b00);
    stim[8]  = alu_op(FN_SRL, OP1_RS1, OP2_RS2, 5'd9, 32'h8000_0000, 32'd33, 32'd0, 32'd0, 2'b00);
    stim[9]  = alu_op(FN_SRA, OP1_RS1, OP2_RS2, 5'd10, 32'h8000_0000, 32'd4, 32'd0, 32'd0, 2'b00);
    stim[10] = alu_op(FN_SRA, OP1_RS1, OP2_RS2, 5'd11, 32'd0, 32'd63, 32'd0, 32'd0, 2'b10);
    stim[11] = '0;
    stim[12] = '0;
    stim[13] = alu_op(FN_ADD, OP1_RS1, OP2_IMM, 5'd13, 32'd0, 32'd0, 32'hffff_f800, 32'd0, 2'b10);
    stim[14] = alu_op(FN_ADD, OP1_PC, OP2_IMM, 5'd14, 32'd0, 32'd0, 32'h12000, 32'h440, 2'b00);
    stim[15] = alu_op(FN_SLTU, OP1_PC, OP2_RS2, 5'd15, 32'd0, 32'd0, 32'd0, 32'h440, 2'b01);
    stim[16] = alu_op(FN_ADD, OP1_RS1, OP2_RS2, 5'd0, 32'd0, 32'd0, 32'd0, 32'd0, 2'b11);
    stim[17] = br_op(BR_EQ, 32'h1234, 32'h1234, 32'h10, 32'h100, 2'b00);
    stim[18] = br_op(BR_NE, 32'h1234, 32'h1234, 32'hffff_fff8, 32'h200, 2'b00);
    stim[19] = br_op(BR_LT, 32'hffff_ffff, 32'd1, 32'h40, 32'h300, 2'b00);
    stim[20] = br_op(BR_GE, 32'h8000_0000, 32'h8000_0000, 32'h20, 32'h304, 2'b00);
    stim[21] = br_op(BR_LTU, 32'hffff_ffff, 32'd1, 32'h80, 32'h308, 2'b00);
    stim[22] = br_op(BR_GEU, 32'd9, 32'd9, 32'hffff_ff00, 32'h1000, 2'b00);
    stim[23] = br_op(BR_GE, 32'd0, 32'd0, 32'h7fc, 32'h2000, 2'b11);

    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_value("wb_data", '0, wb_data);
    check_value("br_target", '0, br_target);

    // Each entry reaches the outputs one cycle after it is driven
    pending = '0;
    for (int i = 0; i < num_entries + 2; i++) begin
      @(posedge clock);
      if (i < num_entries) begin
        e = stim[i];
      end else begin
        e = '0;  // Trailing idle cycles
      end
      a = e.rnd[1] ? $urandom() : e.rs1;
      b = e.rnd[0] ? $urandom() : e.rs2;
      issue     <= e.issue;
      is_branch <= e.is_branch;
      alu_fn    <= e.alu_fn;
      br_fn     <= e.br_fn;
      op1_sel   <= e.op1_sel;
      op2_sel   <= e.op2_sel;
      rd        <= e.rd;
      pc        <= e.pc;
      rs1_data  <= a;
      rs2_data  <= b;
      imm       <= e.imm;
      predicted = model_result(e, a, b);
      @(negedge clock);
      check_value("wb_valid", xlen'(pending.wb_valid), xlen'(wb_valid));
      check_value("br_valid", xlen'(pending.br_valid), xlen'(br_valid));
      if (pending.wb_valid) begin
        check_value("wb_rd", xlen'(pending.wb_rd), xlen'(wb_rd));
        check_value("wb_data", pending.wb_data, wb_data);
      end
      if (pending.br_valid) begin
        check_value("br_taken", xlen'(pending.br_taken), xlen'(br_taken));
        check_value("br_target", pending.br_target, br_target);
      end
      pending = predicted;
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("Timeout after %0d cycles, the stimulus table did not finish", watchdog_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== exec_unit.f ====
verilog/exec_pkg.sv
verilog/operand_mux.sv
verilog/alu.sv
verilog/branch.sv
verilog/exec_writeback.sv
verilog/exec_unit.sv
dv/exec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f exec_unit.f --top-module exec_unit_tb \
  -Mdir obj_dir -o exec_unit_sim > build.log 2>&1 \
  && ./obj_dir/exec_unit_sim > sim.log 2>&1
grep -qx "TB PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  alu_fn_t          fn,
  input  logic [xlen-1:0]  in1,
  input  logic [xlen-1:0]  in2,
  output logic [xlen-1:0]  out
);

  logic signed [xlen-1:0]        signed_in1;
  logic signed [xlen-1:0]        signed_in2;
  logic        [shamt_width-1:0] shamt;
  logic                          lt;
  logic                          ltu;
  logic        [xlen-1:0]        result;

  assign signed_in1 = in1;
  assign signed_in2 = in2;
  assign shamt      = in2[shamt_width-1:0];  // Upper bits of in2 ignored

  assign lt  = signed_in1 < signed_in2;
  assign ltu = in1 < in2;

  // ==========================================================================
  // Function select
  // ==========================================================================

  always_comb begin
    case (fn)
      FN_ADD:  result = in1 + in2;
      FN_SUB:  result = in1 - in2;
      FN_SLT:  result = {{(xlen-1){1'b0}}, lt};
      FN_SLTU: result = {{(xlen-1){1'b0}}, ltu};
      FN_XOR:  result = in1 ^ in2;
      FN_OR:   result = in1 | in2;
      FN_AND:  result = in1 & in2;
      FN_SLL:  result = in1 << shamt;
      FN_SRL:  result = in1 >> shamt;
      FN_SRA:  result = signed_in1 >>> shamt;  // Sign fill
      default: result = '0;
    endcase
  end

  // ==========================================================================
  // Output register
  // ==========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      out <= '0;
    end else begin
      out <= result;
    end
  end

endmodule

// ==== verilog/branch.sv ====
`timescale 1ns/1ps

module branch import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  br_fn_t           fn,
  input  logic [xlen-1:0]  in1,
  input  logic [xlen-1:0]  in2,
  output logic             out
);

  logic signed [xlen-1:0] signed_in1;
  logic signed [xlen-1:0] signed_in2;
  logic                   eq;
  logic                   lt;
  logic                   ltu;
  logic                   result;

  assign signed_in1 = in1;
  assign signed_in2 = in2;

  assign eq  = in1 == in2;
  assign lt  = signed_in1 < signed_in2;
  assign ltu = in1 < in2;

  // GE and GEU are the complements of LT and LTU, so equal operands take the branch
  always_comb begin
    case (fn)
      BR_EQ:   result = eq;
      BR_NE:   result = !eq;
      BR_LT:   result = lt;
      BR_GE:   result = !lt;
      BR_LTU:  result = ltu;
      BR_GEU:  result = !ltu;
      default: result = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out <= 1'b0;
    end else begin
      out <= result;
    end
  end

endmodule

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================

  localparam int xlen           = 32;  // One data word
  localparam int reg_addr_width = 5;
  localparam int shamt_width    = 5;   // Low bits of operand two used as shift amount

  // ==========================================================================
  // Function codes
  // ==========================================================================

  typedef enum logic [3:0] {
    FN_ADD,
    FN_SUB,
    FN_SLT,
    FN_SLTU,
    FN_XOR,
    FN_OR,
    FN_AND,
    FN_SLL,
    FN_SRL,
    FN_SRA
  } alu_fn_t;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,   // Greater or equal, signed
    BR_LTU,
    BR_GEU   // Greater or equal, unsigned
  } br_fn_t;

  // Operand sources
  typedef enum logic {
    OP1_RS1,
    OP1_PC
  } op1_sel_t;

  typedef enum logic {
    OP2_RS2,
    OP2_IMM
  } op2_sel_t;

endpackage

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,

  // Micro-op, sampled when issue is high
  input  logic                       issue,
  input  logic                       is_branch,
  input  alu_fn_t                    alu_fn,
  input  br_fn_t                     br_fn,
  input  op1_sel_t                   op1_sel,
  input  op2_sel_t                   op2_sel,
  input  logic [xlen-1:0]            pc,
  input  logic [xlen-1:0]            rs1_data,
  input  logic [xlen-1:0]            rs2_data,
  input  logic [xlen-1:0]            imm,
  input  logic [reg_addr_width-1:0]  rd,

  // Results, one cycle after issue
  output logic                       wb_valid,
  output logic [reg_addr_width-1:0]  wb_rd,
  output logic [xlen-1:0]            wb_data,
  output logic                       br_valid,
  output logic                       br_taken,
  output logic [xlen-1:0]            br_target
);

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] alu_out;
  logic            taken;

  operand_mux u_operand_mux (
    .op1_sel  (op1_sel),
    .op2_sel  (op2_sel),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .op1      (op1),
    .op2      (op2)
  );

  alu u_alu (
    .clock (clock),
    .reset (reset),
    .fn    (alu_fn),
    .in1   (op1),
    .in2   (op2),
    .out   (alu_out)
  );

  // Branches compare the raw register values, not the muxed operands
  branch u_branch (
    .clock (clock),
    .reset (reset),
    .fn    (br_fn),
    .in1   (rs1_data),
    .in2   (rs2_data),
    .out   (taken)
  );

  exec_writeback u_exec_writeback (
    .clock     (clock),
    .reset     (reset),
    .issue     (issue),
    .is_branch (is_branch),
    .rd        (rd),
    .pc        (pc),
    .imm       (imm),
    .alu_out   (alu_out),
    .taken     (taken),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .br_valid  (br_valid),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

endmodule

// ==== verilog/exec_writeback.sv ====
`timescale 1ns/1ps

module exec_writeback import exec_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       issue,
  input  logic                       is_branch,
  input  logic [reg_addr_width-1:0]  rd,
  input  logic [xlen-1:0]            pc,
  input  logic [xlen-1:0]            imm,
  input  logic [xlen-1:0]            alu_out,
  input  logic                       taken,
  output logic                       wb_valid,
  output logic [reg_addr_width-1:0]  wb_rd,
  output logic [xlen-1:0]            wb_data,
  output logic                       br_valid,
  output logic                       br_taken,
  output logic [xlen-1:0]            br_target
);

  logic                      issue_q;
  logic                      is_branch_q;
  logic [reg_addr_width-1:0] rd_q;
  logic [xlen-1:0]           target_q;

  // ==========================================================================
  // Metadata stage that lines up with the alu and branch registers
  // ==========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_q     <= 1'b0;
      is_branch_q <= 1'b0;
      rd_q        <= '0;
      target_q    <= '0;
    end else begin
      issue_q     <= issue;
      is_branch_q <= is_branch;
      rd_q        <= rd;
      target_q    <= pc + imm;  // Branch target
    end
  end

  // ==========================================================================
  // Output strobes
  // ==========================================================================

  // Writes to x0 are dropped here and nowhere else
  assign wb_valid  = issue_q && !is_branch_q && (rd_q != '0);
  assign wb_rd     = rd_q;
  assign wb_data   = alu_out;

  assign br_valid  = issue_q && is_branch_q;
  assign br_taken  = taken;
  assign br_target = target_q;

endmodule

// ==== verilog/operand_mux.sv ====
`timescale 1ns/1ps

module operand_mux import exec_pkg::*; (
  input  op1_sel_t          op1_sel,
  input  op2_sel_t          op2_sel,
  input  logic [xlen-1:0]   pc,
  input  logic [xlen-1:0]   rs1_data,
  input  logic [xlen-1:0]   rs2_data,
  input  logic [xlen-1:0]   imm,
  output logic [xlen-1:0]   op1,
  output logic [xlen-1:0]   op2
);

  // Operand one comes from the register file or the PC
  // The PC form covers AUIPC-style adds
  always_comb begin
    case (op1_sel)
      OP1_RS1: op1 = rs1_data;
      OP1_PC:  op1 = pc;
      default: op1 = rs1_data;
    endcase
  end

  // Operand two is the second register or the immediate
  always_comb begin
    case (op2_sel)
      OP2_RS2: op2 = rs2_data;
      OP2_IMM: op2 = imm;
      default: op2 = rs2_data;
    endcase
  end

endmodule
